// ==== common/mips_pkg.sv ====
package mips_pkg;

    // A data word as it appears on the bus, in the register file and in the
    // instruction register
    typedef logic [31:0] word_t;

    // Byte address on the Avalon bus
    typedef logic [31:0] addr_t;

    typedef logic [4:0] reg_idx_t;

    // One bit per byte lane, bit 0 is the least significant byte
    typedef logic [3:0] byte_en_t;

    // Primary opcodes, instruction bits 31..26
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SW      = 6'h2B;

    // Function field of SPECIAL instructions, bits 5..0
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;

    // Programs are loaded with their first instruction at this address
    localparam addr_t RESET_VECTOR = 32'h0000_0004;

    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        EXECUTE,
        MEM,
        MEM_WAIT,
        HALTED
    } core_state_t;

endpackage

// ==== cpu/cpu_core.sv ====
module cpu_core (
    input  logic               clk,
    input  logic               rst,
    output logic               active,

    output mips_pkg::addr_t    address,
    output logic               read,
    output logic               write,
    output mips_pkg::word_t    writedata,
    output mips_pkg::byte_en_t byteenable,
    input  mips_pkg::word_t    readdata,
    input  logic               waitrequest,

    output mips_pkg::reg_idx_t rs_idx,
    output mips_pkg::reg_idx_t rt_idx,
    output logic               wr_en,
    output mips_pkg::reg_idx_t wr_idx,
    output mips_pkg::word_t    wr_data,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data
);

    import mips_pkg::*;

    core_state_t state;
    addr_t       pc;
    word_t       ir;

    // Address, data and lanes of the pending load or store
    addr_t       mem_addr;
    word_t       mem_wdata;
    byte_en_t    mem_be;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_idx_t    rd_idx;
    word_t       imm_ext;
    word_t       sum;

    logic        is_addiu;
    logic        is_addu;
    logic        is_jr;
    logic        is_lw;
    logic        is_sw;
    logic        is_sb;
    logic        halt;
    logic        fetch_done;
    logic        mem_done;

    // Instruction fields
    assign opcode  = ir[31:26];
    assign funct   = ir[5:0];
    assign rs_idx  = ir[25:21];
    assign rt_idx  = ir[20:16];
    assign rd_idx  = ir[15:11];
    assign imm_ext = {{16{ir[15]}}, ir[15:0]};

    assign is_addiu = (opcode == OP_ADDIU);
    assign is_addu  = (opcode == OP_SPECIAL) && (funct == FN_ADDU);
    assign is_jr    = (opcode == OP_SPECIAL) && (funct == FN_JR);
    assign is_lw    = (opcode == OP_LW);
    assign is_sw    = (opcode == OP_SW);
    assign is_sb    = (opcode == OP_SB);

    // JR to address zero ends the program
    assign halt = is_jr && (rs_data == '0);

    // One adder serves ADDU, ADDIU and the load/store address
    assign sum = rs_data + (is_addu ? rt_data : imm_ext);

    assign fetch_done = ((state == FETCH) || (state == FETCH_WAIT)) && !waitrequest;
    assign mem_done   = ((state == MEM) || (state == MEM_WAIT)) && !waitrequest;

    // Bus outputs follow the state, so they stay put through wait states
    always_comb begin
        address    = pc;
        read       = 1'b0;
        write      = 1'b0;
        writedata  = mem_wdata;
        byteenable = 4'b1111;
        case (state)
            FETCH, FETCH_WAIT: begin
                read = 1'b1;
            end
            MEM, MEM_WAIT: begin
                address    = mem_addr;
                byteenable = mem_be;
                if (is_lw) begin
                    read = 1'b1;
                end else begin
                    write = 1'b1;
                end
            end
            default: begin
                read = 1'b0;
            end
        endcase
    end

    // Register write back, from the adder or from a completed load
    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = rt_idx;
        wr_data = sum;
        if (state == EXECUTE) begin
            if (is_addiu) begin
                wr_en = 1'b1;
            end else if (is_addu) begin
                wr_en  = 1'b1;
                wr_idx = rd_idx;
            end
        end else if (mem_done && is_lw) begin
            wr_en   = 1'b1;
            wr_data = readdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= FETCH;
            pc     <= RESET_VECTOR;
            active <= 1'b0;
        end else begin
            if (state != HALTED) begin
                active <= 1'b1;
            end
            case (state)
                FETCH: begin
                    state <= waitrequest ? FETCH_WAIT : EXECUTE;
                end
                FETCH_WAIT: begin
                    if (!waitrequest) begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (halt) begin
                        state  <= HALTED;
                        active <= 1'b0;
                    end else if (is_jr) begin
                        pc    <= rs_data;
                        state <= FETCH;
                    end else if (is_lw || is_sw || is_sb) begin
                        state <= MEM;
                    end else begin
                        // Unknown opcodes fall through here as no-ops
                        pc    <= pc + 32'd4;
                        state <= FETCH;
                    end
                end
                MEM: begin
                    if (waitrequest) begin
                        state <= MEM_WAIT;
                    end else begin
                        pc    <= pc + 32'd4;
                        state <= FETCH;
                    end
                end
                MEM_WAIT: begin
                    if (!waitrequest) begin
                        pc    <= pc + 32'd4;
                        state <= FETCH;
                    end
                end
                HALTED: begin
                    state <= HALTED;
                end
                default: begin
                    state <= FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            ir <= readdata;
        end
        if (state == EXECUTE) begin
            mem_addr <= sum;
            if (is_sb) begin
                // Move the byte onto the lane picked by the low address bits
                mem_wdata <= word_t'(rt_data[7:0]) << {sum[1:0], 3'b000};
                mem_be    <= byte_en_t'(4'b0001 << sum[1:0]);
            end else begin
                mem_wdata <= rt_data;
                mem_be    <= 4'b1111;
            end
        end
    end

endmodule

// ==== cpu/cpu_regfile.sv ====
module cpu_regfile (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    input  logic               wr_en,
    input  mips_pkg::reg_idx_t wr_idx,
    input  mips_pkg::word_t    wr_data,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    output mips_pkg::word_t    register_v0
);

    import mips_pkg::*;

    word_t regs [32];

    // Register 0 always reads as zero, whatever the array holds
    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

    // $v0 is where test programs leave their result
    assign register_v0 = regs[2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

// ==== hdl/avalon_ram.sv ====
module avalon_ram #(
    parameter int unsigned RAM_WORDS = 64
) (
    input  logic               clk,
    input  logic               rst,

    input  mips_pkg::addr_t    address,
    input  logic               read,
    input  logic               write,
    input  mips_pkg::word_t    writedata,
    input  mips_pkg::byte_en_t byteenable,
    output mips_pkg::word_t    readdata,
    output logic               waitrequest,

    input  logic               load_en,
    input  logic [7:0]         load_addr,
    input  mips_pkg::word_t    load_data
);

    import mips_pkg::*;

    localparam int unsigned IDX_W = $clog2(RAM_WORDS);

    word_t mem [RAM_WORDS];

    logic [IDX_W-1:0] bus_idx;
    logic [IDX_W-1:0] load_idx;
    addr_t            load_byte_addr;

    // High while the first cycle of a read is over and its data is ready
    logic rd_wait;

    // Word index from the byte address, wrapping at the memory size
    assign bus_idx        = address[IDX_W+1:2];
    assign load_byte_addr = addr_t'(load_addr);
    assign load_idx       = load_byte_addr[IDX_W+1:2];

    // A read stalls for exactly one cycle; writes never stall
    assign waitrequest = read && !rd_wait;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= read && !rd_wait;
        end
    end

    always_ff @(posedge clk) begin
        if (read && !rd_wait) begin
            readdata <= mem[bus_idx];
        end
    end

    // The preload port wins over a bus write in the same cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    mem[bus_idx][8*b +: 8] <= writedata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== hdl/mips_system.sv ====
module mips_system #(
    parameter int unsigned RAM_WORDS = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            load_en,
    input  logic [7:0]      load_addr,
    input  mips_pkg::word_t load_data,
    output logic            active,
    output mips_pkg::word_t register_v0
);

    import mips_pkg::*;

    // Avalon bus between the core and the memory
    addr_t    address;
    logic     read;
    logic     write;
    word_t    writedata;
    byte_en_t byteenable;
    word_t    readdata;
    logic     waitrequest;

    // Register file ports
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;
    word_t    rs_data;
    word_t    rt_data;

    cpu_core i_cpu_core (
        .clk         (clk),
        .rst         (rst),
        .active      (active),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data)
    );

    cpu_regfile i_cpu_regfile (
        .clk         (clk),
        .rst         (rst),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

    avalon_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) i_avalon_ram (
        .clk         (clk),
        .rst         (rst),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

endmodule

// ==== src.f ====
common/mips_pkg.sv
cpu/cpu_regfile.sv
cpu/cpu_core.sv
hdl/avalon_ram.sv
hdl/mips_system.sv
test/mips_system_checker.sv
test/mips_system_tb.sv

// ==== test/mips_system_checker.sv ====
module mips_system_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  active,
    input  mips_pkg::addr_t       address,
    input  logic                  read,
    input  logic                  write,
    input  mips_pkg::word_t       writedata,
    input  mips_pkg::byte_en_t    byteenable,
    input  logic                  waitrequest,
    input  logic                  wr_en,
    input  mips_pkg::core_state_t state
);

    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    // Count of failed assertions
    int unsigned assert_failures = 0;

    bus_exclusive: assert property (@(posedge clk) disable iff (rst) !(read && write))
        else begin
            $error("read and write are high in the same cycle");
            assert_failures++;
        end

    // A stalled transfer must be presented again unchanged
    bus_held: assert property (@(posedge clk) disable iff (rst)
        (read || write) && waitrequest
            |=> $stable({address, read, write, writedata, byteenable}))
        else begin
            $error("bus outputs changed while waitrequest was high");
            assert_failures++;
        end

    idle_in_reset: assert property (@(posedge clk) rst |=> !active)
        else begin
            $error("active is high while rst is asserted");
            assert_failures++;
        end

    no_write_after_halt: assert property (@(posedge clk) disable iff (rst)
        (state == HALTED) |-> !wr_en)
        else begin
            $error("register write in the HALTED state");
            assert_failures++;
        end

endmodule

bind cpu_core mips_system_checker i_mips_system_checker (
    .clk         (clk),
    .rst         (rst),
    .active      (active),
    .address     (address),
    .read        (read),
    .write       (write),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .waitrequest (waitrequest),
    .wr_en       (wr_en),
    .state       (state)
);

// ==== test/mips_system_tb.sv ====
module mips_system_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    localparam int NUM_TESTS    = 8;
    localparam int MAX_INSTR    = 8;
    localparam int RESET_CYCLES = 4;
    // Eight five-cycle instructions plus reset for every test, with a margin of two
    localparam int CYCLE_LIMIT  = NUM_TESTS * (MAX_INSTR * 5 + RESET_CYCLES) * 2;
    localparam logic [31:0] SEED = 32'd93141;

    logic       clk = 1'b0;
    logic       rst;
    logic       load_en;
    logic [7:0] load_addr;
    word_t      load_data;
    logic       active;
    word_t      register_v0;

    // Program table, one row per test
    string      test_name   [NUM_TESTS];
    int         prog_len    [NUM_TESTS];
    logic [7:0] prog_addr   [NUM_TESTS][MAX_INSTR];
    word_t      prog_instr  [NUM_TESTS][MAX_INSTR];
    word_t      expected_v0 [NUM_TESTS];

    int n_tests     = 0;
    int error_count = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int cycle_count = 0;

    mips_system #(
        .RAM_WORDS (64)
    ) i_mips_system (
        .clk         (clk),
        .rst         (rst),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .active      (active),
        .register_v0 (register_v0)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic word_t encode_itype(input logic [5:0] op, input reg_idx_t rs,
                                           input reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encode_rtype(input reg_idx_t rs, input reg_idx_t rt,
                                           input reg_idx_t rd, input logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    task automatic check_value(input string name, input string what,
                               input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s %s = %h, expected %h",
                     $time, name, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic add_test(input string name, input word_t expected);
        test_name[n_tests]   = name;
        expected_v0[n_tests] = expected;
        prog_len[n_tests]    = 0;
        n_tests++;
    endtask

    task automatic add_instr(input logic [7:0] addr, input word_t instr);
        int t;
        int k;
        t = n_tests - 1;
        k = prog_len[t];
        prog_addr[t][k]  = addr;
        prog_instr[t][k] = instr;
        prog_len[t]      = k + 1;
    endtask

    task automatic build_table();
        logic [31:0] rand_state;
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        word_t       jr_zero;
        jr_zero    = encode_rtype(5'd0, 5'd0, 5'd0, FN_JR);
        rand_state = next_random(SEED);
        imm_a      = rand_state[31:16];
        rand_state = next_random(rand_state);
        imm_b      = rand_state[31:16];

        add_test("addiu_negative", 32'hFFFF_FFCC);
        add_instr(8'h04, encode_itype(OP_ADDIU, 5'd0, 5'd2, 16'hFFCC));
        add_instr(8'h08, jr_zero);

        // Both immediates are sign extended before the add
        add_test("addiu_random", {{16{imm_a[15]}}, imm_a} + {{16{imm_b[15]}}, imm_b});
        add_instr(8'h04, encode_itype(OP_ADDIU, 5'd0, 5'd3, imm_a));
        add_instr(8'h08, encode_itype(OP_ADDIU, 5'd3, 5'd2, imm_b));
        add_instr(8'h0C, jr_zero);

        // 0xFFFFFFFF plus 5 wraps to 4
        add_test("addu_wrap", 32'h0000_0004);
        add_instr(8'h04, encode_itype(OP_ADDIU, 5'd0, 5'd3, 16'hFFFF));
        add_instr(8'h08, encode_itype(OP_ADDIU, 5'd0, 5'd4, 16'h0005));
        add_instr(8'h0C, encode_rtype(5'd3, 5'd4, 5'd2, FN_ADDU));
        add_instr(8'h10, jr_zero);

        add_test("sw_lw", 32'h0000_5A5A);
        add_instr(8'h04, encode_itype(OP_ADDIU, 5'd0, 5'd3, 16'h5A5A));
        add_instr(8'h08, encode_itype(OP_ADDIU, 5'd0, 5'd5, 16'h0090));
        add_instr(8'h0C, encode_itype(OP_SW, 5'd5, 5'd3, 16'h0004));
        add_instr(8'h10, encode_itype(OP_LW, 5'd5, 5'd2, 16'h0004));
        add_instr(8'h14, jr_zero);

        // The word at 0x80 is 0xFFFF8765 before the byte store
        add_test("sb_lane1", 32'hFFFF_AB65);
        add_instr(8'h04, encode_itype(OP_ADDIU, 5'd0, 5'd3, 16'h8765));
        add_instr(8'h08, encode_itype(OP_SW, 5'd0, 5'd3, 16'h0080));
        add_instr(8'h0C, encode_itype(OP_ADDIU, 5'd0, 5'd4, 16'h00AB));
        add_instr(8'h10, encode_itype(OP_SB, 5'd0, 5'd4, 16'h0081));
        add_instr(8'h14, encode_itype(OP_LW, 5'd0, 5'd2, 16'h0080));
        add_instr(8'h18, jr_zero);

        add_test("sb_lane3", 32'hABFF_8765);
        add_instr(8'h04, encode_itype(OP_ADDIU, 5'd0, 5'd3, 16'h8765));
        add_instr(8'h08, encode_itype(OP_SW, 5'd0, 5'd3, 16'h0080));
        add_instr(8'h0C, encode_itype(OP_ADDIU, 5'd0, 5'd4, 16'h00AB));
        add_instr(8'h10, encode_itype(OP_SB, 5'd0, 5'd4, 16'h0083));
        add_instr(8'h14, encode_itype(OP_LW, 5'd0, 5'd2, 16'h0080));
        add_instr(8'h18, jr_zero);

        add_test("jr_halt", 32'h0000_0055);
        add_instr(8'h04, encode_itype(OP_ADDIU, 5'd0, 5'd2, 16'h0055));
        add_instr(8'h08, jr_zero);
        add_instr(8'h0C, encode_itype(OP_ADDIU, 5'd0, 5'd2, 16'h0077));

        // $v0 held 0x55 before this reset, so only a cleared file gives 0x100
        add_test("rerun_clear", 32'h0000_0100);
        add_instr(8'h04, encode_itype(OP_ADDIU, 5'd2, 5'd2, 16'h0100));
        add_instr(8'h08, jr_zero);
    endtask

    // Holds rst for at least four cycles and loads one word per cycle meanwhile
    task automatic run_program(input int t);
        int n;
        int i;
        n   = (prog_len[t] > RESET_CYCLES) ? prog_len[t] : RESET_CYCLES;
        rst = 1'b1;
        for (i = 0; i < n; i++) begin
            load_en = (i < prog_len[t]);
            if (i < prog_len[t]) begin
                load_addr = prog_addr[t][i];
                load_data = prog_instr[t][i];
            end
            @(posedge clk);
            #2;
        end
        load_en = 1'b0;
        rst     = 1'b0;
    endtask

    task automatic wait_halt();
        @(negedge clk);
        while (!active) begin
            @(negedge clk);
        end
        while (active) begin
            @(negedge clk);
        end
        // Any stray write after the halt would show up in these cycles
        repeat (2) @(negedge clk);
    endtask

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int          errors_before;
        int unsigned assert_errors;
        rst       = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        build_table();
        @(posedge clk);
        #2;
        for (int t = 0; t < n_tests; t++) begin
            errors_before = error_count;
            run_program(t);
            wait_halt();
            check_value(test_name[t], "register_v0", register_v0, expected_v0[t]);
            // A halted core stays idle until the next reset
            check_value(test_name[t], "active", word_t'(active), 32'd0);
            if (error_count == errors_before) begin
                pass_count++;
                $display("Test %-16s passed", test_name[t]);
            end else begin
                fail_count++;
                $display("Test %-16s failed", test_name[t]);
            end
            @(posedge clk);
            #2;
        end
        assert_errors = i_mips_system.i_cpu_core.i_mips_system_checker.assert_failures;
        $display("Tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 pass_count, fail_count, assert_errors);
        if ((fail_count == 0) && (assert_errors == 0)) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
